// File: flist.f
verilog/snd_pkg.sv
verilog/snd_decode.sv
verilog/snd_ram.sv
verilog/snd_comm_latch.sv
verilog/snd_fm_timer.sv
verilog/snd_board.sv
tb/snd_board_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the sound board testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module snd_board_tb \
    -Mdir obj_dir -o snd_board_sim

./obj_dir/snd_board_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: tb/snd_board_tb.sv
// directed testbench playing the Z80 and main CPU; ROM model returns rom_addr[7:0] ^ 8'h5a
`default_nettype none
`timescale 1ns/1ps

module snd_board_tb import snd_pkg::*; ();

    localparam int half_period  = 50;
    localparam int sample_delay = 40;   // just before the rising edge
    localparam int flag_timeout = 400;  // cycles
    localparam int nmi_timeout  = 8;

    logic                  clk;
    logic                  rst;
    logic                  cen_8;
    logic                  cen_4;
    logic [1:0]            phase;
    logic [15:0]           addr;
    logic [7:0]            cpu_dout;
    logic                  rd_n;
    logic                  wr_n;
    logic                  mreq_n;
    logic                  rfsh_n;
    logic                  iorq_n;
    logic [7:0]            rom_data;
    logic                  rom_ok;
    logic [4:1]            main_addr;
    logic [7:0]            main_dout;
    logic                  pair_we;
    logic                  snd_irq;
    logic [7:0]            cpu_din;
    logic                  cpu_cen;
    logic [snd_rom_aw-1:0] rom_addr;
    logic                  rom_cs;
    logic                  int_n;
    logic                  nmi_n;
    logic [7:0]            pair_dout;

    integer seed = 32'hfa95ec86;
    int     errors = 0;
    int     timeouts = 0;

    // bus state captured by the last bus_read
    logic                  seen_cen;
    logic                  seen_cen4;
    logic                  seen_cen8;
    logic                  seen_rom_cs;
    logic [snd_rom_aw-1:0] seen_rom_addr;

    logic [15:0] ram_a [0:31];
    logic [7:0]  ram_d [0:31];

    assign rom_data = rom_addr[7:0] ^ 8'h5a;  // ROM model

    snd_board #(.RAM_AW(snd_ram_aw_def)) dut_i (
        .clk       (clk),
        .rst       (rst),
        .cen_8     (cen_8),
        .cen_4     (cen_4),
        .addr      (addr),
        .cpu_dout  (cpu_dout),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .mreq_n    (mreq_n),
        .rfsh_n    (rfsh_n),
        .iorq_n    (iorq_n),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .main_addr (main_addr),
        .main_dout (main_dout),
        .pair_we   (pair_we),
        .snd_irq   (snd_irq),
        .cpu_din   (cpu_din),
        .cpu_cen   (cpu_cen),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .int_n     (int_n),
        .nmi_n     (nmi_n),
        .pair_dout (pair_dout)
    );

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // cen_8 every 2nd clk, cen_4 every 4th, both changed on the falling edge
    initial begin
        cen_8 = 1'b0;
        cen_4 = 1'b0;
        phase = 2'd0;
        forever begin
            @(negedge clk);
            phase = phase + 2'd1;
            cen_8 = !phase[0];
            cen_4 = phase == 2'd0;
        end
    end

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // every bus task starts and ends on a falling edge and takes one clk
    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        addr   = a;
        mreq_n = 1'b0;
        rd_n   = 1'b0;
        #(sample_delay);
        d             = cpu_din;
        seen_cen      = cpu_cen;
        seen_cen4     = cen_4;
        seen_cen8     = cen_8;
        seen_rom_cs   = rom_cs;
        seen_rom_addr = rom_addr;
        @(negedge clk);
        mreq_n = 1'b1;
        rd_n   = 1'b1;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        addr     = a;
        cpu_dout = d;
        mreq_n   = 1'b0;
        wr_n     = 1'b0;
        @(negedge clk);
        mreq_n = 1'b1;
        wr_n   = 1'b1;
    endtask

    task automatic refresh_write(input logic [15:0] a, input logic [7:0] d);
        rfsh_n = 1'b0;
        bus_write(a, d);
        rfsh_n = 1'b1;
    endtask

    task automatic bank_write(input logic [3:0] b, input logic clr);
        snd_bank_u bw;
        bw.raw       = 8'h00;
        bw.f.nmi_clr = clr;
        bw.f.bank    = b;
        bus_write(16'hf800, bw.raw);
    endtask

    task automatic main_write(input logic [4:1] a, input logic [7:0] d);
        main_addr = a;
        main_dout = d;
        pair_we   = 1'b1;
        @(negedge clk);
        pair_we = 1'b0;
    endtask

    task automatic main_read(input logic [4:1] a, output logic [7:0] d);
        main_addr = a;
        #(sample_delay);
        d = pair_dout;
        @(negedge clk);
    endtask

    task automatic pulse_irq();
        snd_irq = 1'b1;
        @(negedge clk);
        snd_irq = 1'b0;
    endtask

    task automatic iorq_cycle();
        iorq_n = 1'b0;
        @(negedge clk);
        iorq_n = 1'b1;
    endtask

    task automatic rom_read_check(input logic [15:0] a, input logic [2:0] exp_hi);
        logic [7:0] d;
        bus_read(a, d);
        compare_byte(d, a[7:0] ^ 8'h5a, "ROM data");
        assert (seen_rom_addr === {exp_hi, a[13:0]}) else begin
            $display("Mismatch at %0t ns: rom_addr %h for %h, expected %h", $time,
                     seen_rom_addr, a, {exp_hi, a[13:0]});
            errors++;
        end
        check_level(seen_rom_cs, 1'b1, "rom_cs on ROM read");
        check_level(seen_cen, seen_cen4, "cpu_cen on ROM read");
    endtask

    task automatic check_rom_map();
        logic [7:0] hi;
        logic [7:0] lo;
        logic [7:0] d;
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            hi = random_byte();
            lo = random_byte();
            rom_read_check({1'b0, hi[6:0], lo}, {2'b00, hi[6]});
        end
        for (int k = 0; k < 4; k++) begin
            b = random_byte();
            bank_write(b[3:0], 1'b0);
            for (int j = 0; j < 3; j++) begin
                hi = random_byte();
                lo = random_byte();
                rom_read_check({2'b10, hi[5:0], lo}, b[2:0]);  // only 3 bank bits reach the ROM
            end
        end
        for (int i = 0; i < 4; i++) begin
            hi = random_byte();
            lo = random_byte();
            bus_read({5'b11100, hi[2:0], lo}, d);
            compare_byte(d, 8'hff, "PCM area read");
            check_level(seen_rom_cs, 1'b0, "rom_cs on PCM read");
            check_level(seen_cen, seen_cen8, "cpu_cen on PCM read");
        end
    endtask

    task automatic check_ram();
        logic [7:0] d;
        for (int i = 0; i < 32; i++) begin
            ram_a[i] = {3'b110, i[4:0], random_byte()};
            ram_d[i] = random_byte();
            bus_write(ram_a[i], ram_d[i]);
        end
        for (int i = 0; i < 32; i++) begin
            bus_read(ram_a[i], d);
            compare_byte(d, ram_d[i], "RAM read back");
            check_level(seen_cen, seen_cen4, "cpu_cen on RAM read");
        end
        refresh_write(ram_a[0], ~ram_d[0]);
        bus_read(ram_a[0], d);
        compare_byte(d, ram_d[0], "RAM after refresh write");
    endtask

    task automatic check_mailbox();
        logic [7:0] c0;
        logic [7:0] c1;
        logic [7:0] r0;
        logic [7:0] r1;
        logic [7:0] d;
        c0 = random_byte();
        c1 = random_byte();
        r0 = random_byte();
        r1 = random_byte();
        main_write(4'd0, c0);
        main_write(4'd1, c1);
        for (int i = 0; i < 4; i++) begin  // one full cen_4 period
            bus_read(16'hf000, d);
            compare_byte(d, c0, "command 0");
            check_level(seen_cen, seen_cen8, "cpu_cen on latch read");
        end
        bus_read(16'hf001, d);
        compare_byte(d, c1, "command 1");
        bus_write(16'hf002, r0);
        bus_write(16'hf003, r1);
        main_read(4'd2, d);
        compare_byte(d, r0, "reply 0");
        main_read(4'd3, d);
        compare_byte(d, r1, "reply 1");
        main_read(4'd0, d);
        compare_byte(d, 8'h00, "pair_dout at command address");
    endtask

    task automatic check_sound_irq();
        check_level(int_n, 1'b1, "int_n before pulse");
        pulse_irq();
        check_level(int_n, 1'b0, "int_n after pulse");
        pulse_irq();  // absorbed while pending
        check_level(int_n, 1'b0, "int_n across second pulse");
        iorq_cycle();
        check_level(int_n, 1'b1, "int_n after iorq cycle");
        @(negedge clk);  // latch re-arms once iorq_n is high
        check_level(int_n, 1'b1, "int_n before re-arm pulse");
        pulse_irq();
        check_level(int_n, 1'b0, "int_n after re-arm pulse");
        iorq_cycle();
        @(negedge clk);
    endtask

    task automatic check_timer_nmi();
        logic [7:0] r;
        logic [7:0] l;
        logic [7:0] st;
        logic       got_flag;
        int         ticks;
        r = random_byte();
        l = {4'he, r[3:0]};  // 17 to 32 ticks
        check_level(nmi_n, 1'b1, "nmi_n before timer start");
        bus_write(16'he800, fm_reg_tload);
        bus_write(16'he801, l);
        bus_write(16'he800, fm_reg_tctl);
        bus_write(16'he801, 8'h05);  // start, irq enable
        ticks    = 0;
        got_flag = 1'b0;
        for (int i = 0; i < flag_timeout && !got_flag; i++) begin
            bus_read(16'he801, st);
            check_level(seen_cen, seen_cen8, "cpu_cen on FM read");
            if (st[0]) begin
                got_flag = 1'b1;
            end else if (seen_cen4) begin
                ticks++;  // this cen_4 is seen at the coming rising edge
            end
        end
        if (!got_flag) begin
            $display("timeout waiting for timer flag at %0t ns", $time);
            timeouts++;
        end else begin
            assert (ticks >= 256 - int'(l)) else begin
                $display("Mismatch at %0t ns: flag after %0d ticks, load %h", $time, ticks, l);
                errors++;
            end
            compare_byte(st, 8'h01, "timer status");
        end
        for (int i = 0; i < nmi_timeout && nmi_n; i++) begin
            @(negedge clk);
        end
        if (nmi_n) begin
            $display("timeout waiting for nmi_n to fall at %0t ns", $time);
            timeouts++;
        end
        bank_write(4'h3, 1'b0);
        check_level(nmi_n, 1'b0, "nmi_n after bank write without clear");
        bank_write(4'hd, 1'b1);
        check_level(nmi_n, 1'b1, "nmi_n after bank write with clear");
        rom_read_check(16'h8000 | {8'h00, random_byte()}, 3'd5);
        bus_write(16'he800, fm_reg_tctl);
        bus_write(16'he801, 8'h04);  // stop first so no overflow races the reset
        bus_write(16'he801, 8'h10);
        bus_read(16'he801, st);
        compare_byte(st, 8'h00, "timer status after flag reset");
        check_level(nmi_n, 1'b1, "nmi_n after flag reset");
    endtask

    initial begin
        rst       = 1'b1;
        addr      = 16'h0000;
        cpu_dout  = 8'h00;
        rd_n      = 1'b1;
        wr_n      = 1'b1;
        mreq_n    = 1'b1;
        rfsh_n    = 1'b1;
        iorq_n    = 1'b1;
        rom_ok    = 1'b1;
        main_addr = 4'd0;
        main_dout = 8'h00;
        pair_we   = 1'b0;
        snd_irq   = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_level(nmi_n, 1'b1, "nmi_n after reset");
        check_level(int_n, 1'b1, "int_n after reset");
        check_level(rom_cs, 1'b0, "rom_cs on idle bus");
        check_rom_map();
        check_ram();
        check_mailbox();
        check_sound_irq();
        check_timer_nmi();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/snd_board.sv
// sound board glue for an external Z80; rom_ok is not used here and only feeds the bus model
`default_nettype none
`timescale 1ns/1ps

module snd_board import snd_pkg::*; #(
    parameter int RAM_AW = snd_ram_aw_def
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   cen_8,
    input  wire                   cen_4,
    input  wire [15:0]            addr,
    input  wire [7:0]             cpu_dout,
    input  wire                   rd_n,
    input  wire                   wr_n,
    input  wire                   mreq_n,
    input  wire                   rfsh_n,
    input  wire                   iorq_n,
    input  wire [7:0]             rom_data,
    input  wire                   rom_ok,     // CPU wait, handled outside
    input  wire [4:1]             main_addr,
    input  wire [7:0]             main_dout,
    input  wire                   pair_we,
    input  wire                   snd_irq,
    output logic [7:0]            cpu_din,
    output logic                  cpu_cen,
    output logic [snd_rom_aw-1:0] rom_addr,
    output logic                  rom_cs,
    output logic                  int_n,
    output logic                  nmi_n,
    output logic [7:0]            pair_dout
);

    logic       ram_cs, fm_cs, latch_cs;
    logic [7:0] ram_dout, fm_dout, latch_dout;
    logic       fm_irq_n;

    snd_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .mreq_n     (mreq_n),
        .rfsh_n     (rfsh_n),
        .rd_n       (rd_n),
        .wr_n       (wr_n),
        .cpu_dout   (cpu_dout),
        .cen_8      (cen_8),
        .cen_4      (cen_4),
        .rom_data   (rom_data),
        .ram_dout   (ram_dout),
        .fm_dout    (fm_dout),
        .latch_dout (latch_dout),
        .fm_irq_n   (fm_irq_n),
        .cpu_din    (cpu_din),
        .cpu_cen    (cpu_cen),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .ram_cs     (ram_cs),
        .fm_cs      (fm_cs),
        .latch_cs   (latch_cs),
        .nmi_n      (nmi_n)
    );

    snd_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk  (clk),
        .addr (addr[RAM_AW-1:0]),
        .cs   (ram_cs),
        .wr_n (wr_n),
        .din  (cpu_dout),
        .dout (ram_dout)
    );

    snd_comm_latch u_latch (
        .clk       (clk),
        .rst       (rst),
        .main_addr (main_addr),
        .main_dout (main_dout),
        .pair_we   (pair_we),
        .snd_irq   (snd_irq),
        .saddr     (addr[1:0]),
        .sdin      (cpu_dout),
        .cs        (latch_cs),
        .wr_n      (wr_n),
        .iorq_n    (iorq_n),
        .pair_dout (pair_dout),
        .sdout     (latch_dout),
        .int_n     (int_n)
    );

    snd_fm_timer u_fm (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen_4),
        .cs    (fm_cs),
        .wr_n  (wr_n),
        .a0    (addr[0]),
        .din   (cpu_dout),
        .dout  (fm_dout),
        .irq_n (fm_irq_n)
    );

endmodule

`default_nettype wire

// File: verilog/snd_comm_latch.sv
// main/sound mailbox with sound interrupt; int_n clears on any IORQ cycle, not only on acknowledge
`default_nettype none
`timescale 1ns/1ps

module snd_comm_latch (
    input  wire        clk,
    input  wire        rst,
    input  wire [4:1]  main_addr,
    input  wire [7:0]  main_dout,
    input  wire        pair_we,
    input  wire        snd_irq,
    input  wire [1:0]  saddr,
    input  wire [7:0]  sdin,
    input  wire        cs,
    input  wire        wr_n,
    input  wire        iorq_n,
    output logic [7:0] pair_dout,
    output logic [7:0] sdout,
    output logic       int_n
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_pend = 2'd1;  // int_n held low
    localparam logic [1:0] st_ack  = 2'd2;  // waiting for iorq_n to rise

    logic [7:0] cmd0, cmd1;  // main to sound
    logic [7:0] rep0, rep1;  // sound to main
    logic [1:0] state;
    logic       snd_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd0 <= 8'd0;
            cmd1 <= 8'd0;
        end else if (pair_we) begin
            if (main_addr == 4'd0) cmd0 <= main_dout;
            if (main_addr == 4'd1) cmd1 <= main_dout;
        end
    end

    // sound side only writes the reply pair
    assign snd_we = cs && !wr_n && saddr[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rep0 <= 8'd0;
            rep1 <= 8'd0;
        end else if (snd_we) begin
            if (saddr[0]) rep1 <= sdin;
            else          rep0 <= sdin;
        end
    end

    always_comb begin
        case (saddr)
            2'd0:    sdout = cmd0;
            2'd1:    sdout = cmd1;
            2'd2:    sdout = rep0;  // replies read back
            default: sdout = rep1;
        endcase
    end

    always_comb begin
        case (main_addr)
            4'd2:    pair_dout = rep0;
            4'd3:    pair_dout = rep1;
            default: pair_dout = 8'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (snd_irq) state <= st_pend;
                st_pend: if (!iorq_n) state <= st_ack;  // extra snd_irq absorbed
                st_ack:  if (iorq_n)  state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    assign int_n = state != st_pend;

endmodule

`default_nettype wire

// File: verilog/snd_decode.sv
// sound bus decoder, bank register and NMI latch; ROM is read-only so rom_cs needs rd_n low
`default_nettype none
`timescale 1ns/1ps

module snd_decode import snd_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [15:0]            addr,
    input  wire                   mreq_n,
    input  wire                   rfsh_n,
    input  wire                   rd_n,
    input  wire                   wr_n,
    input  wire [7:0]             cpu_dout,
    input  wire                   cen_8,
    input  wire                   cen_4,
    input  wire [7:0]             rom_data,
    input  wire [7:0]             ram_dout,
    input  wire [7:0]             fm_dout,
    input  wire [7:0]             latch_dout,
    input  wire                   fm_irq_n,
    output logic [7:0]            cpu_din,
    output logic                  cpu_cen,
    output logic [snd_rom_aw-1:0] rom_addr,
    output logic                  rom_cs,
    output logic                  ram_cs,
    output logic                  fm_cs,
    output logic                  latch_cs,
    output logic                  nmi_n
);

    logic       mem_acc;
    logic       bank_we;
    logic [2:0] bank;      // only 8 banks are wired to the ROM
    logic [2:0] rom_hi;
    snd_bank_u  bank_byte;
    logic       fm_irq_l;  // fm_irq_n one clk ago
    logic       nmi_set;

    // refresh cycles also pull mreq_n low
    assign mem_acc = !mreq_n && rfsh_n;

    always_comb begin
        rom_cs   = mem_acc && !(addr[15] && addr[14]) && !rd_n;  // 0000-BFFF
        ram_cs   = mem_acc && addr[15:13] == snd_ram_hi;
        fm_cs    = mem_acc && addr[15:12] == snd_io_hi && addr[11];
        latch_cs = mem_acc && addr[15:12] == snd_ctl_hi && !addr[11];
        bank_we  = mem_acc && addr[15:12] == snd_ctl_hi && addr[11] && !addr[10] && !wr_n;
    end

    // 0000-7FFF is fixed, 8000-BFFF is the banked window
    assign rom_hi   = addr[15] ? bank : {2'b00, addr[14]};
    assign rom_addr = {rom_hi, addr[13:0]};

    // ROM and RAM cycles run on the slower enable
    assign cpu_cen = (rom_cs || ram_cs) ? cen_4 : cen_8;

    // PCM area has no model here, falls through to open bus
    always_comb begin
        if (rom_cs) begin
            cpu_din = rom_data;
        end else if (ram_cs) begin
            cpu_din = ram_dout;
        end else if (fm_cs) begin
            cpu_din = fm_dout;
        end else if (latch_cs) begin
            cpu_din = latch_dout;
        end else begin
            cpu_din = snd_open_bus;
        end
    end

    assign bank_byte.raw = cpu_dout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 3'd0;
        end else if (bank_we) begin
            bank <= bank_byte.f.bank[2:0];
        end
    end

    // falling edge of the FM interrupt
    assign nmi_set = fm_irq_l && !fm_irq_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fm_irq_l <= 1'b1;
            nmi_n    <= 1'b1;
        end else begin
            fm_irq_l <= fm_irq_n;
            if (nmi_set) begin
                nmi_n <= 1'b0;  // a new edge is never lost to a clear
            end else if (bank_we && bank_byte.f.nmi_clr) begin
                nmi_n <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/snd_fm_timer.sv
// FM chip stand-in with register port and timer A only; no synthesis, busy flag reads as 0
`default_nettype none
`timescale 1ns/1ps

module snd_fm_timer import snd_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        cen,
    input  wire        cs,
    input  wire        wr_n,
    input  wire        a0,
    input  wire [7:0]  din,
    output logic [7:0] dout,
    output logic       irq_n
);

    // control register bits
    localparam int ctl_start    = 0;
    localparam int ctl_irq_en   = 2;
    localparam int ctl_flag_rst = 4;

    logic [7:0] reg_addr;  // selected by an a0=0 write
    logic [7:0] tload;
    logic       start;
    logic       irq_en;
    logic       flag;
    logic [7:0] cnt;
    logic       wr_addr;
    logic       wr_data;
    logic       flag_clr;

    assign wr_addr  = cs && !wr_n && !a0;
    assign wr_data  = cs && !wr_n && a0;
    assign flag_clr = wr_data && reg_addr == fm_reg_tctl && din[ctl_flag_rst];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_addr <= 8'd0;
            tload    <= 8'd0;
            start    <= 1'b0;
            irq_en   <= 1'b0;
        end else begin
            if (wr_addr) begin
                reg_addr <= din;
            end
            if (wr_data && reg_addr == fm_reg_tload) begin
                tload <= din;
            end
            if (wr_data && reg_addr == fm_reg_tctl) begin
                start  <= din[ctl_start];
                irq_en <= din[ctl_irq_en];
            end
        end
    end

    // up-counter, 256 - tload ticks per period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= 8'd0;
            flag <= 1'b0;
        end else begin
            if (flag_clr) flag <= 1'b0;
            if (!start) begin
                cnt <= tload;  // preloaded while stopped
            end else if (cen) begin
                if (cnt == 8'hff) begin
                    cnt  <= tload;
                    flag <= 1'b1;  // overflow beats a same-cycle reset
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end
        end
    end

    // status read, busy in bit 7
    assign dout  = {7'd0, flag};
    assign irq_n = !(flag && irq_en);

endmodule

`default_nettype wire

// File: verilog/snd_pkg.sv
// sound memory map and shared widths; the map assumes a 64 KB Z80 space and a 128 KB sound ROM
`default_nettype none

package snd_pkg;

    // sound ROM: 8 banks of 16 KB
    localparam int snd_rom_aw     = 17;
    localparam int snd_ram_aw_def = 13;  // 8 KB work RAM at C000-DFFF

    // region tags, compared against the top address bits
    localparam logic [2:0] snd_ram_hi = 3'b110;
    localparam logic [3:0] snd_io_hi  = 4'he;   // A11 splits FM and PCM
    localparam logic [3:0] snd_ctl_hi = 4'hf;   // latch, bank register

    localparam logic [7:0] snd_open_bus = 8'hff;

    // FM timer register numbers
    localparam logic [7:0] fm_reg_tload = 8'h10;
    localparam logic [7:0] fm_reg_tctl  = 8'h14;

    // bank register write byte
    typedef struct packed {
        logic [2:0] unused;
        logic       nmi_clr;
        logic [3:0] bank;
    } snd_bank_s;

    typedef union packed {
        logic [7:0] raw;
        snd_bank_s  f;
    } snd_bank_u;

endpackage

`default_nettype wire

// File: verilog/snd_ram.sv
// byte-wide work RAM, read is asynchronous so it maps to distributed RAM or flops only
`default_nettype none
`timescale 1ns/1ps

module snd_ram #(
    parameter int RAM_AW = 13
) (
    input  wire              clk,
    input  wire [RAM_AW-1:0] addr,
    input  wire              cs,
    input  wire              wr_n,
    input  wire [7:0]        din,
    output logic [7:0]       dout
);

    logic [7:0] mem [0:2**RAM_AW-1];  // contents undefined after power-up

    always_ff @(posedge clk) begin
        if (cs && !wr_n) begin
            mem[addr] <= din;
        end
    end

    // the CPU samples read data later in the cycle
    assign dout = mem[addr];

endmodule

`default_nettype wire
